/* filelist.f */
design/prefetch_pkg.sv
design/prefetch_fsm.sv
design/ip_counter.sv
design/prefetch_fifo.sv
design/immediate_reader.sv
design/instr_prefetch_unit.sv
tb/prefetch_mem_model.sv
tb/instr_prefetch_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the prefetch testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module instr_prefetch_tb -f filelist.f -o sim_prefetch \
    && ./obj_dir/sim_prefetch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure"; exit 1; } || exit 0

/* tb/instr_prefetch_tb.sv */
`timescale 1ns/1ps

module instr_prefetch_tb;

    localparam int unsigned seed = 32'h51a4;
    // Tests need a few hundred cycles at worst ack delay
    localparam int timeout_cycles = 4000;
    localparam int fill_pause     = 40;

    logic        clk;
    logic        rst_n;
    logic        load_new_ip;
    logic [15:0] new_cs;
    logic [15:0] new_ip;
    logic [19:1] mem_addr;
    logic        mem_access;
    logic [15:0] mem_data;
    logic        mem_ack;
    logic        immed_start;
    logic        immed_is_8bit;
    logic        immed_busy;
    logic        immed_complete;
    logic [15:0] immediate;
    logic [15:0] ip_current;
    logic        fifo_empty;

    logic [15:0] model_cs;
    logic [15:0] model_ip;
    int cycle_count    = 0;
    int total_checks   = 0;
    int total_errors   = 0;
    int test_checks    = 0;
    int test_errors    = 0;
    int ip_checks      = 0;
    int ip_errors      = 0;
    int addr_hold_errs = 0;
    int ack_errs       = 0;
    int drop_errs      = 0;

    instr_prefetch_unit u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_new_ip    (load_new_ip),
        .new_cs         (new_cs),
        .new_ip         (new_ip),
        .mem_addr       (mem_addr),
        .mem_access     (mem_access),
        .mem_data       (mem_data),
        .mem_ack        (mem_ack),
        .immed_start    (immed_start),
        .immed_is_8bit  (immed_is_8bit),
        .immed_busy     (immed_busy),
        .immed_complete (immed_complete),
        .immediate      (immediate),
        .ip_current     (ip_current),
        .fifo_empty     (fifo_empty)
    );

    prefetch_mem_model u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_addr   (mem_addr),
        .mem_access (mem_access),
        .mem_data   (mem_data),
        .mem_ack    (mem_ack)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Access and address hold until the ack
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_access && !mem_ack) |=> (mem_access && $stable(mem_addr)))
    else begin
        addr_hold_errs++;
        $display("Bus protocol error at %0t ns: access or address changed before ack", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) mem_ack |-> mem_access)
    else begin
        ack_errs++;
        $display("Bus protocol error at %0t ns: ack seen without an access", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) mem_ack |=> !mem_access)
    else begin
        drop_errs++;
        $display("Bus protocol error at %0t ns: access still high after ack", $time);
    end

    function automatic logic [19:0] linear_of(input logic [15:0] cs, input logic [15:0] ip);
        return {cs, 4'h0} + {4'h0, ip};
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [19:0] addr);
        logic [19:0] v;
        v = addr * 20'd7 + 20'd3;
        return v[7:0];
    endfunction

    task automatic check(input string name, input logic [19:0] exp_val,
                         input logic [19:0] act_val, input logic ip_track);
        total_checks++;
        if (ip_track) begin
            ip_checks++;
        end else begin
            test_checks++;
        end
        assert (act_val === exp_val) else begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h",
                     $time, name, exp_val, act_val);
            total_errors++;
            if (ip_track) begin
                ip_errors++;
            end else begin
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic check_reset_outputs();
        check("mem_access", 20'(1'b0), 20'(mem_access), 1'b0);
        check("immed_busy", 20'(1'b0), 20'(immed_busy), 1'b0);
        check("immed_complete", 20'(1'b0), 20'(immed_complete), 1'b0);
        check("fifo_empty", 20'(1'b1), 20'(fifo_empty), 1'b0);
        check("ip_current", 20'(16'h0000), 20'(ip_current), 1'b0);
    endtask

    task automatic redirect(input logic [15:0] cs, input logic [15:0] ip,
                            output logic pending);
        @(posedge clk);
        load_new_ip <= 1'b1;
        new_cs      <= cs;
        new_ip      <= ip;
        @(negedge clk);
        // What the FSM samples on the redirect edge
        pending = mem_access && !mem_ack;
        @(posedge clk);
        load_new_ip <= 1'b0;
        model_cs = cs;
        model_ip = ip;
    endtask

    task automatic read_immediate(input logic w8);
        logic [15:0] exp_val;
        int          gap;
        gap     = $urandom_range(3, 0);
        exp_val = {8'h00, pattern_byte(linear_of(model_cs, model_ip))};
        if (!w8) begin
            exp_val[15:8] = pattern_byte(linear_of(model_cs, model_ip + 16'd1));
        end
        model_ip = model_ip + (w8 ? 16'd1 : 16'd2);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        immed_start   <= 1'b1;
        immed_is_8bit <= w8;
        @(posedge clk);
        immed_start <= 1'b0;
        @(negedge clk);
        while (!immed_complete) begin
            @(negedge clk);
        end
        check("immediate", 20'(exp_val), 20'(immediate), 1'b0);
        check("ip_current", 20'(model_ip), 20'(ip_current), 1'b1);
    endtask

    initial begin
        logic        hit;
        logic [15:0] try_cs;
        logic [15:0] try_ip;
        int          i;
        int          proto_total;
        int          all_errors;
        void'($urandom(seed));
        clk           = 1'b0;
        rst_n         = 1'b0;
        load_new_ip   = 1'b0;
        new_cs        = 16'h0000;
        new_ip        = 16'h0000;
        immed_start   = 1'b0;
        immed_is_8bit = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs();
        while (!mem_access) begin
            @(negedge clk);
        end
        check("mem_addr", 20'(linear_of(16'hffff, 16'h0000) >> 1), 20'(mem_addr), 1'b0);
        finish_test("reset state");

        redirect(16'h1234, 16'h0100, hit);
        for (i = 0; i < 10; i++) begin
            read_immediate(1'b1);
        end
        finish_test("byte order");

        // Odd IP, and the segment wraps past 1 MB
        redirect(16'hfff8, 16'h00f7, hit);
        for (i = 0; i < 8; i++) begin
            read_immediate(1'b0);
        end
        finish_test("16-bit immediates");

        hit    = 1'b0;
        try_cs = 16'h2000;
        try_ip = 16'h0123;
        for (i = 0; i < 8 && !hit; i++) begin
            redirect(try_cs, try_ip, hit);
            try_cs = try_cs + 16'h0010;
            try_ip = try_ip + 16'h0002;
            @(negedge clk);
            while (!(mem_access && !mem_ack)) begin
                @(negedge clk);
            end
        end
        if (!hit) begin
            $display("Redirect test: no redirect landed on an outstanding bus access");
            total_errors++;
            test_errors++;
        end
        // No reads here, so the queue fills up
        repeat (fill_pause) @(posedge clk);
        for (i = 0; i < 8; i++) begin
            read_immediate(i[0]);
        end
        finish_test("redirect during access");

        $display("ip tracking: %0d checks, %0d errors", ip_checks, ip_errors);
        proto_total = addr_hold_errs + ack_errs + drop_errs;
        $display("bus protocol: %0d violations", proto_total);

        all_errors = total_errors + proto_total;
        $display("checks %0d, errors %0d", total_checks, all_errors);
        if (all_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb/prefetch_mem_model.sv */
`timescale 1ns/1ps

module prefetch_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [19:1] mem_addr,
    input  logic        mem_access,
    output logic [15:0] mem_data,
    output logic        mem_ack
);

    logic       pending;
    logic [1:0] wait_left;
    int         delay;

    // Byte at a linear address is low 8 bits of addr * 7 + 3
    function automatic logic [7:0] pattern_byte(input logic [19:0] addr);
        logic [19:0] v;
        v = addr * 20'd7 + 20'd3;
        return v[7:0];
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ack   <= 1'b0;
            pending   <= 1'b0;
            wait_left <= 2'd0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
            pending <= 1'b0;
        end else if (mem_access) begin
            if (!pending) begin
                delay = $urandom_range(3, 0);
                if (delay == 0) begin
                    mem_ack  <= 1'b1;
                    mem_data <= {pattern_byte({mem_addr, 1'b1}), pattern_byte({mem_addr, 1'b0})};
                end else begin
                    pending   <= 1'b1;
                    wait_left <= 2'(delay);
                end
            end else if (wait_left == 2'd1) begin
                mem_ack  <= 1'b1;
                mem_data <= {pattern_byte({mem_addr, 1'b1}), pattern_byte({mem_addr, 1'b0})};
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

/* design/instr_prefetch_unit.sv */
`timescale 1ns/1ps

module instr_prefetch_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_new_ip,
    input  logic [15:0]                         new_cs,
    input  logic [15:0]                         new_ip,
    output logic [prefetch_pkg::addr_width-1:1] mem_addr,
    output logic                                mem_access,
    input  prefetch_pkg::fetch_word_t           mem_data,
    input  logic                                mem_ack,
    input  logic                                immed_start,
    input  logic                                immed_is_8bit,
    output logic                                immed_busy,
    output logic                                immed_complete,
    output logic [prefetch_pkg::word_width-1:0] immediate,
    output logic [15:0]                         ip_current,
    output logic                                fifo_empty
);
    import prefetch_pkg::*;

    logic                  fifo_wr_en;
    logic [byte_width-1:0] fifo_wr_data;
    logic                  fifo_flush;
    logic                  fifo_nearly_full;
    logic                  fifo_rd_en;
    logic [byte_width-1:0] fifo_rd_data;

    prefetch_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_new_ip      (load_new_ip),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .fifo_nearly_full (fifo_nearly_full),
        .mem_ack          (mem_ack),
        .mem_data         (mem_data),
        .mem_addr         (mem_addr),
        .mem_access       (mem_access),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .fifo_flush       (fifo_flush)
    );

    // Every byte popped advances the architectural IP
    ip_counter u_ip (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load_new_ip),
        .inc        (fifo_rd_en),
        .load_val   (new_ip),
        .ip_current (ip_current)
    );

    prefetch_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (fifo_flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    immediate_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .busy         (immed_busy),
        .complete     (immed_complete),
        .immediate    (immediate)
    );

endmodule

/* design/immediate_reader.sv */
`timescale 1ns/1ps

module immediate_reader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                is_8bit,
    input  logic [prefetch_pkg::byte_width-1:0] fifo_rd_data,
    input  logic                                fifo_empty,
    output logic                                fifo_rd_en,
    output logic                                busy,
    output logic                                complete,
    output logic [prefetch_pkg::word_width-1:0] immediate
);
    import prefetch_pkg::*;

    logic fetching;
    logic width_8;
    logic have_low;
    logic cur_8bit;
    logic cur_have_low;
    logic last_byte;

    // Start cycle already pops when a byte is waiting
    assign cur_8bit     = start ? is_8bit : width_8;
    assign cur_have_low = start ? 1'b0 : have_low;
    assign busy         = start || fetching;
    assign fifo_rd_en   = busy && !fifo_empty;
    assign last_byte    = fifo_rd_en && (cur_8bit || cur_have_low);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetching <= 1'b0;
            complete <= 1'b0;
            width_8  <= 1'b0;
            have_low <= 1'b0;
        end else begin
            complete <= last_byte;
            fetching <= busy && !last_byte;
            if (start) begin
                width_8 <= is_8bit;
            end
            if (last_byte) begin
                have_low <= 1'b0;
            end else if (fifo_rd_en) begin
                have_low <= 1'b1;
            end else begin
                have_low <= cur_have_low;
            end
        end
    end

    // First byte zero-extends, second fills the top half
    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            if (!cur_have_low) begin
                immediate <= {{(word_width - byte_width){1'b0}}, fifo_rd_data};
            end else begin
                immediate[word_width-1:byte_width] <= fifo_rd_data;
            end
        end
    end

endmodule

/* design/prefetch_fifo.sv */
`timescale 1ns/1ps

module prefetch_fifo (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                wr_en,
    input  logic [prefetch_pkg::byte_width-1:0] wr_data,
    input  logic                                rd_en,
    output logic [prefetch_pkg::byte_width-1:0] rd_data,
    output logic                                empty,
    output logic                                nearly_full
);
    import prefetch_pkg::*;

    logic [byte_width-1:0]       mem [fifo_depth];
    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [fifo_count_width-1:0] count;
    logic                        do_wr;
    logic                        do_rd;

    function automatic logic [fifo_ptr_width-1:0] next_ptr(input logic [fifo_ptr_width-1:0] p);
        if (p == fifo_ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_wr = wr_en && (count != fifo_count_width'(fifo_depth));
    assign do_rd = rd_en && !empty;

    assign empty       = (count == '0);
    // Fewer than two slots left
    assign nearly_full = (count >= fifo_count_width'(fifo_depth - 1));
    assign rd_data     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr && !flush) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* design/ip_counter.sv */
`timescale 1ns/1ps

module ip_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic        inc,
    input  logic [15:0] load_val,
    output logic [15:0] ip_current
);
    import prefetch_pkg::*;

    // Load beats increment, wraps at 64 KB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ip_current <= reset_ip;
        end else if (load) begin
            ip_current <= load_val;
        end else if (inc) begin
            ip_current <= ip_current + 16'd1;
        end
    end

endmodule

/* design/prefetch_fsm.sv */
`timescale 1ns/1ps

module prefetch_fsm (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    load_new_ip,
    input  logic [15:0]                             new_cs,
    input  logic [15:0]                             new_ip,
    input  logic                                    fifo_nearly_full,
    input  logic                                    mem_ack,
    input  prefetch_pkg::fetch_word_t               mem_data,
    output logic [prefetch_pkg::addr_width-1:1]     mem_addr,
    output logic                                    mem_access,
    output logic                                    fifo_wr_en,
    output logic [prefetch_pkg::byte_width-1:0]     fifo_wr_data,
    output logic                                    fifo_flush
);
    import prefetch_pkg::*;

    logic [2:0]            state;
    logic [15:0]           fetch_cs;
    logic [15:0]           fetch_ip;
    logic [15:0]           fetch_ip_inc;
    logic [addr_width-1:0] linear_cur;
    logic [addr_width-1:0] linear_inc;
    logic                  in_write;
    fetch_word_t           word_q;

    // Segment base plus offset, wrapping at 1 MB
    function automatic logic [addr_width-1:0] linear_addr(input logic [15:0] cs,
                                                          input logic [15:0] ip);
        logic [addr_width-1:0] base;
        base = {{(addr_width - word_width){1'b0}}, cs} << segment_shift;
        return base + {{(addr_width - word_width){1'b0}}, ip};
    endfunction

    assign fetch_ip_inc = fetch_ip + 16'd1;
    assign linear_cur   = linear_addr(fetch_cs, fetch_ip);
    assign linear_inc   = linear_addr(fetch_cs, fetch_ip_inc);

    // Bytes go out straight from the captured word
    assign in_write     = (state == st_write_low) || (state == st_write_high);
    assign fifo_wr_en   = in_write && !fifo_nearly_full && !load_new_ip;
    assign fifo_wr_data = (state == st_write_low) ? word_q.bytes.low : word_q.bytes.high;
    assign fifo_flush   = load_new_ip;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            mem_access <= 1'b0;
            fetch_cs   <= reset_cs;
            fetch_ip   <= reset_ip;
        end else if (load_new_ip) begin
            fetch_cs <= new_cs;
            fetch_ip <= new_ip;
            // An access in flight must still finish on the bus
            if (mem_access && !mem_ack) begin
                state <= st_discard;
            end else begin
                state      <= st_idle;
                mem_access <= 1'b0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (!fifo_nearly_full) begin
                        state      <= st_access;
                        mem_access <= 1'b1;
                        mem_addr   <= linear_cur[addr_width-1:1];
                    end
                end
                st_access: begin
                    if (mem_ack) begin
                        mem_access <= 1'b0;
                        word_q     <= mem_data;
                        // Odd IP skips the byte below it
                        state      <= fetch_ip[0] ? st_write_high : st_write_low;
                    end
                end
                st_write_low: begin
                    if (fifo_wr_en) begin
                        fetch_ip <= fetch_ip_inc;
                        state    <= st_write_high;
                    end
                end
                st_write_high: begin
                    if (fifo_wr_en) begin
                        fetch_ip   <= fetch_ip_inc;
                        state      <= st_access;
                        mem_access <= 1'b1;
                        mem_addr   <= linear_inc[addr_width-1:1];
                    end
                end
                st_discard: begin
                    // Stale word is dropped
                    if (mem_ack) begin
                        mem_access <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: begin
                    state      <= st_idle;
                    mem_access <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* design/prefetch_pkg.sv */
package prefetch_pkg;

    // Bus and address geometry
    localparam int addr_width    = 20;
    localparam int word_width    = 16;
    localparam int byte_width    = 8;
    localparam int segment_shift = 4;

    // Prefetch queue sizing
    localparam int fifo_depth       = 6;
    localparam int fifo_ptr_width   = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // Architectural state out of reset
    localparam logic [15:0] reset_cs = 16'hffff;
    localparam logic [15:0] reset_ip = 16'h0000;

    // Fetch FSM state encodings
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_access     = 3'd1;
    localparam logic [2:0] st_write_low  = 3'd2;
    localparam logic [2:0] st_write_high = 3'd3;
    localparam logic [2:0] st_discard    = 3'd4;

    // One bus word, or its two bytes with low at the even address
    typedef union packed {
        logic [word_width-1:0] word;
        struct packed {
            logic [byte_width-1:0] high;
            logic [byte_width-1:0] low;
        } bytes;
    } fetch_word_t;

endpackage
